// File: hdl/frame_accumulator.sv
`timescale 1ns/1ns

module frame_accumulator #(
	parameter int LANES = 128,
	parameter int FRAME_BEATS = 128
) (
	input logic clk,
	input logic rst_n,
	input logic valid,
	input hll_pkg::estimate_t partial,
	input logic out_ready,
	output logic out_valid,
	output hll_pkg::estimate_t out_data
);

	// register stages in rank_reduce_tree, leaf + adder levels + output
	localparam int TREE_DEPTH = $clog2(LANES) + 1;
	localparam int CNT_BITS = (FRAME_BEATS > 1) ? $clog2(FRAME_BEATS) : 1;
	localparam logic [CNT_BITS-1:0] LAST_BEAT = CNT_BITS'(FRAME_BEATS - 1);

	logic [TREE_DEPTH-1:0] valid_pipe;
	logic [CNT_BITS-1:0] beat_cnt;
	logic [CNT_BITS-1:0] beat_pipe [TREE_DEPTH];

	logic beat_valid;
	logic first_beat;
	logic last_beat;

	hll_pkg::estimate_t total;
	logic frame_done;

	// tree output and its tags, all at the same depth
	assign beat_valid = valid_pipe[TREE_DEPTH-1];
	assign first_beat = beat_pipe[TREE_DEPTH-1] == '0;
	assign last_beat = beat_pipe[TREE_DEPTH-1] == LAST_BEAT;

	// valid follows the beat through the tree
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[TREE_DEPTH-2:0], valid};
		end
	end

	// position of the incoming beat within its frame
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			beat_cnt <= '0;
		end else if (valid) begin
			if (beat_cnt == LAST_BEAT) begin
				beat_cnt <= '0;
			end else begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	// beat position delayed alongside valid, only read when valid is set
	always_ff @(posedge clk) begin
		beat_pipe[0] <= beat_cnt;
		for (int i = 1; i < TREE_DEPTH; i++) begin
			beat_pipe[i] <= beat_pipe[i-1];
		end
	end

	// running total for the current frame
	always_ff @(posedge clk) begin
		if (beat_valid) begin
			if (first_beat) begin
				total <= partial; // new frame starts from its own first beat
			end else begin
				total <= hll_pkg::est_add(total, partial);
			end
		end
	end

	// final beat added on this edge, total is complete one cycle later
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			frame_done <= 1'b0;
		end else begin
			frame_done <= beat_valid & last_beat;
		end
	end

	// held estimate, a completed frame wins over a release
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (frame_done) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (frame_done) begin
			out_data <= total; // overwrites an estimate not yet taken
		end
	end

endmodule

// File: hdl/hll_estimator_top.sv
`timescale 1ns/1ns

module hll_estimator_top #(
	parameter int LANES = 128,
	parameter int FRAME_BEATS = 128,
	localparam int BEAT_BITS = LANES * hll_pkg::RANK_BITS
) (
	input logic clk,
	input logic rst_n,
	input logic valid,
	input logic [BEAT_BITS-1:0] data,
	input logic out_ready,
	output logic out_valid,
	output hll_pkg::estimate_t out_data
);

	// one reduced beat per clock, validity tracked in the accumulator
	hll_pkg::estimate_t partial;

	rank_reduce_tree #(
		.LANES(LANES)
	) u_tree (
		.clk(clk),
		.data(data),
		.partial(partial)
	);

	frame_accumulator #(
		.LANES(LANES),
		.FRAME_BEATS(FRAME_BEATS)
	) u_acc (
		.clk(clk),
		.rst_n(rst_n),
		.valid(valid),
		.partial(partial),
		.out_ready(out_ready),
		.out_valid(out_valid),
		.out_data(out_data)
	);

endmodule

// File: hdl/hll_pkg.sv
package hll_pkg;

	// width of one register rank
	localparam int RANK_BITS = 4;

	// harmonic sum weight of a rank of zero, 2^16
	localparam logic [16:0] SCALE_ONE = 17'd65536;

	localparam int SUM_BITS = 32;
	localparam int ZERO_BITS = 16;

	typedef logic [RANK_BITS-1:0] rank_t;
	typedef logic [SUM_BITS-1:0] sum_t;
	typedef logic [ZERO_BITS-1:0] zero_t;

	// sum sits in the upper bits, zero count in the lower bits
	typedef struct packed {
		sum_t sum;
		zero_t zeros;
	} estimate_t;

	// adds both fields of two estimates
	// serves the tree levels and the frame accumulator
	function automatic estimate_t est_add(
		input estimate_t a,
		input estimate_t b
	);
		estimate_t r;
		r.sum = a.sum + b.sum;
		r.zeros = a.zeros + b.zeros;
		return r;
	endfunction

endpackage

// File: hdl/rank_reduce_tree.sv
`timescale 1ns/1ns

module rank_reduce_tree #(
	parameter int LANES = 128,
	localparam int BEAT_BITS = LANES * hll_pkg::RANK_BITS
) (
	input logic clk,
	input logic [BEAT_BITS-1:0] data,
	output hll_pkg::estimate_t partial
);

	// level 0 holds LANES/2 leaf nodes, the last level holds one node
	localparam int LEVELS = $clog2(LANES);
	localparam int RB = hll_pkg::RANK_BITS;

	// weight of a single rank in the harmonic sum
	function automatic hll_pkg::sum_t rank_weight(
		input hll_pkg::rank_t r
	);
		return hll_pkg::sum_t'(hll_pkg::SCALE_ONE) >> r;
	endfunction

	// one leaf node covers two neighbouring ranks
	function automatic hll_pkg::estimate_t leaf_node(
		input hll_pkg::rank_t lo,
		input hll_pkg::rank_t hi
	);
		hll_pkg::estimate_t n;
		n.sum = rank_weight(lo) + rank_weight(hi);
		n.zeros = hll_pkg::zero_t'(lo == '0) + hll_pkg::zero_t'(hi == '0);
		return n;
	endfunction

	for (genvar lv = 0; lv < LEVELS; lv++) begin : g_lvl
		localparam int NODES = LANES >> (lv + 1);

		hll_pkg::estimate_t node [NODES];

		if (lv == 0) begin : g_leaf
			// rank to weight conversion and zero flags, registered per pair
			always_ff @(posedge clk) begin
				for (int p = 0; p < NODES; p++) begin
					node[p] <= leaf_node(
						data[(2 * p) * RB +: RB],
						data[(2 * p + 1) * RB +: RB]
					);
				end
			end
		end else begin : g_add
			// pairwise add of the level above, one register stage per level
			always_ff @(posedge clk) begin
				for (int p = 0; p < NODES; p++) begin
					node[p] <= hll_pkg::est_add(
						g_lvl[lv-1].node[2 * p],
						g_lvl[lv-1].node[2 * p + 1]
					);
				end
			end
		end
	end

	// output stage, keeps the root adder off the accumulator path
	// total latency LEVELS + 1 cycles, matched by the valid delay line
	always_ff @(posedge clk) begin
		partial <= g_lvl[LEVELS-1].node[0];
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# builds the HyperLogLog estimator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ns -j 0 \
	--top-module hll_estimator_tb -f verilog.f; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vhll_estimator_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "^Simulation finished: PASS$"; then
	exit 0
fi

echo "pass message not found in the simulation output"
exit 1

// File: verification/hll_estimator_tb.sv
`timescale 1ns/1ns

module hll_estimator_tb;

	localparam int LANES = 128;
	localparam int FRAME_BEATS = 8;
	localparam int BEAT_BITS = LANES * hll_pkg::RANK_BITS;
	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	// last beat taken to out_valid high, tree depth plus the frame-end stage
	localparam int LATENCY = $clog2(LANES) + 2;
	localparam string TRACE_FILE = "verification/hll_trace.txt";

	logic clk;
	logic rst_n;
	logic valid;
	logic [BEAT_BITS-1:0] data;
	logic out_ready;
	logic out_valid;
	hll_pkg::estimate_t out_data;

	int edge_no;
	int frame_beat;
	hll_pkg::estimate_t frame_total;
	logic exp_valid;
	hll_pkg::estimate_t exp_data;
	int due_edge_q[$]; // edge at which a completed frame appears
	hll_pkg::estimate_t due_est_q[$];
	hll_pkg::estimate_t calc_q[$]; // computed from the beats, waiting for the trace line
	hll_pkg::estimate_t file_q[$];
	int watchdog_ns;

	hll_estimator_top #(
		.LANES(LANES),
		.FRAME_BEATS(FRAME_BEATS)
	) UUT (
		.clk(clk),
		.rst_n(rst_n),
		.valid(valid),
		.data(data),
		.out_ready(out_ready),
		.out_valid(out_valid),
		.out_data(out_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_valid(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("MISMATCH at %0t ns: %s expected %b actual %b",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_estimate(
		input string name,
		input hll_pkg::estimate_t expected,
		input hll_pkg::estimate_t actual
	);
		if (actual !== expected) begin
			stop_on_error($sformatf(
				"MISMATCH at %0t ns: %s expected sum %h zeros %h actual sum %h zeros %h",
				$time, name, expected.sum, expected.zeros, actual.sum, actual.zeros));
		end
	endtask

	// each rank adds 65536 >> rank, ranks of zero are counted
	function automatic hll_pkg::estimate_t beat_estimate(input logic [BEAT_BITS-1:0] beat);
		hll_pkg::estimate_t e;
		hll_pkg::rank_t r;
		e = '0;
		for (int i = 0; i < LANES; i++) begin
			r = beat[i * hll_pkg::RANK_BITS +: hll_pkg::RANK_BITS];
			e.sum = e.sum + (hll_pkg::sum_t'(65536) >> r);
			if (r == '0) begin
				e.zeros = e.zeros + hll_pkg::zero_t'(1);
			end
		end
		return e;
	endfunction

	task automatic match_trace_expectations();
		hll_pkg::estimate_t from_beats;
		hll_pkg::estimate_t from_file;
		while (calc_q.size() > 0 && file_q.size() > 0) begin
			from_beats = calc_q.pop_front();
			from_file = file_q.pop_front();
			if (from_beats !== from_file) begin
				stop_on_error($sformatf(
					"trace error: file lists sum %h zeros %h but its beats give sum %h zeros %h",
					from_file.sum, from_file.zeros, from_beats.sum, from_beats.zeros));
			end
		end
	endtask

	// expected output after the edge just passed, from the inputs driven before it
	task automatic model_edge();
		hll_pkg::estimate_t beat;
		edge_no++;
		if (due_edge_q.size() > 0 && due_edge_q[0] == edge_no) begin
			exp_valid = 1'b1; // completing frame wins over out_ready
			exp_data = due_est_q.pop_front();
			void'(due_edge_q.pop_front());
		end else if (out_ready) begin
			exp_valid = 1'b0;
		end
		if (valid) begin
			beat = beat_estimate(data);
			if (frame_beat == 0) begin
				frame_total = beat; // a frame holds nothing of the one before
			end else begin
				frame_total.sum = frame_total.sum + beat.sum;
				frame_total.zeros = frame_total.zeros + beat.zeros;
			end
			frame_beat++;
			if (frame_beat == FRAME_BEATS) begin
				due_edge_q.push_back(edge_no + LATENCY);
				due_est_q.push_back(frame_total);
				calc_q.push_back(frame_total);
				frame_beat = 0;
			end
		end
	endtask

	task automatic advance_cycle();
		@(negedge clk);
		model_edge();
		check_valid("out_valid", exp_valid, out_valid);
		if (exp_valid) begin
			check_estimate("out_data", exp_data, out_data);
		end
		match_trace_expectations();
	endtask

	initial begin
		wait (watchdog_ns > 0);
		#(watchdog_ns);
		stop_on_error($sformatf("timeout: the run did not finish within %0d ns", watchdog_ns));
	end

	initial begin
		int fd;
		int n_lines;
		int n_fields;
		string line;
		logic [7:0] tag;
		logic v;
		logic r;
		logic [BEAT_BITS-1:0] d;
		hll_pkg::sum_t s;
		hll_pkg::zero_t z;
		hll_pkg::estimate_t e;

		clk = 1'b0;
		rst_n = 1'b0;
		valid = 1'b0;
		data = '0;
		out_ready = 1'b0;
		edge_no = 0;
		frame_beat = 0;
		frame_total = '0;
		exp_valid = 1'b0;
		exp_data = '0;

		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			stop_on_error({"cannot open the trace file ", TRACE_FILE});
		end
		n_lines = 0;
		while ($fgets(line, fd) != 0) begin
			n_lines++;
		end
		$fclose(fd);
		watchdog_ns = (n_lines + RESET_CYCLES + 20) * CLK_PERIOD;

		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_valid("out_valid", 1'b0, out_valid);
		end
		rst_n = 1'b1;

		fd = $fopen(TRACE_FILE, "r");
		while ($fgets(line, fd) != 0) begin
			tag = (line.len() > 1) ? line.getc(0) : "#";
			case (tag)
				"B": begin
					n_fields = $sscanf(line, "B %b %b %h", v, r, d);
					if (n_fields != 3) begin
						stop_on_error({"malformed beat line in the trace: ", line});
					end
					valid = v;
					out_ready = r;
					data = d;
					advance_cycle();
				end
				"E": begin
					n_fields = $sscanf(line, "E %h %h", s, z);
					if (n_fields != 2) begin
						stop_on_error({"malformed expectation line in the trace: ", line});
					end
					e.sum = s;
					e.zeros = z;
					file_q.push_back(e);
					match_trace_expectations();
				end
				"#": begin
				end
				default: begin
					stop_on_error({"unknown line in the trace: ", line});
				end
			endcase
		end
		$fclose(fd);

		valid = 1'b0;
		out_ready = 1'b0;
		while (due_edge_q.size() > 0) begin
			advance_cycle();
		end
		advance_cycle();

		if (calc_q.size() != 0 || file_q.size() != 0) begin
			stop_on_error($sformatf(
				"trace error: %0d computed and %0d listed estimates have no partner",
				calc_q.size(), file_q.size()));
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

// File: verification/hll_trace.txt
# B <valid> <out_ready> <beat data, 128 hex ranks, lane 0 rightmost>
# E <expected sum, hex> <expected zero count, hex> of the next estimate
# frame A, beats spread out by idle cycles
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 1 1 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 1 1 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
B 1 1 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 1 1 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
B 1 1 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 1 1 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 1 1 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0
B 1 1 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0
E 014001c0 0120
# frame A drains through the tree and is taken
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
# frames B and C back to back, all ranks zero then all ranks at 15
B 1 1 00000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000
B 1 1 00000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000
B 1 1 00000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000
B 1 1 00000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000
B 1 1 00000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000
B 1 1 00000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000
B 1 1 00000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000
B 1 1 00000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000
E 04000000 0400
B 1 1 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
B 1 1 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
B 1 1 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
B 1 1 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
B 1 1 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
B 1 1 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
B 1 1 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
B 1 1 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
E 00000800 0000
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
# frame D, then the estimate is held while out_ready stays low
B 1 0 11111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111
B 1 0 11111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111111
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 1 0 88888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888
B 1 0 88888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888888
B 1 0 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
B 1 0 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
B 1 0 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
B 1 0 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
E 00c0ffc0 0020
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
# one release edge, then out_valid stays low
B 0 1 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
B 0 0 55555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555

// File: verilog.f
hdl/hll_pkg.sv
hdl/rank_reduce_tree.sv
hdl/frame_accumulator.sv
hdl/hll_estimator_top.sv
verification/hll_estimator_tb.sv
